// ==== Bender.yml ====
package:
  name: core_slice

sources:
  - logic/core_pkg.sv
  - logic/instr_decoder.sv
  - logic/reg_file.sv
  - logic/decode_stage.sv
  - logic/execute_stage.sv
  - logic/result_stage.sv
  - logic/core_top.sv
  - target: test
    files:
      - test/core_props.sv
      - test/core_tb.sv

// ==== compile.f ====
logic/core_pkg.sv
logic/instr_decoder.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/core_top.sv
test/core_props.sv
test/core_tb.sv

// ==== logic/core_pkg.sv ====
`default_nettype none

package core_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;

  // Major opcodes of the supported RV32I subset
  localparam logic [6:0] op_lui = 7'b0110111;
  localparam logic [6:0] op_auipc = 7'b0010111;
  localparam logic [6:0] op_jal = 7'b1101111;
  localparam logic [6:0] op_jalr = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_imm = 7'b0010011;
  localparam logic [6:0] op_reg = 7'b0110011;
  localparam logic [6:0] op_system = 7'b1110011;

  // Whole encodings of the two system instructions
  localparam logic [xlen-1:0] instr_ecall = 32'h00000073;
  localparam logic [xlen-1:0] instr_ebreak = 32'h00100073;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b // Only LUI uses this
  } alu_op_t;

  // Encoded as funct3 of the branch instructions
  typedef enum logic [2:0] {
    bcu_beq = 3'b000,
    bcu_bne = 3'b001,
    bcu_blt = 3'b100,
    bcu_bge = 3'b101,
    bcu_bltu = 3'b110,
    bcu_bgeu = 3'b111
  } bcu_op_t;

  // Machine cause codes from the privileged spec
  typedef enum logic [3:0] {
    except_illegal_instruction = 4'd2,
    except_breakpoint = 4'd3,
    except_env_call_mach = 4'd11
  } ecause_t;

endpackage

`default_nettype wire

// ==== logic/core_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module core_top #(
  parameter int num_regs = 32
) (
  input logic clk,
  input logic rst,
  input logic issue_valid,
  input logic [core_pkg::xlen-1:0] issue_instr,
  input logic [core_pkg::xlen-1:0] issue_pc,
  output logic retire_valid,
  output logic [core_pkg::xlen-1:0] retire_pc,
  output logic rd_wren,
  output logic [core_pkg::reg_addr_w-1:0] rd_addr,
  output logic [core_pkg::xlen-1:0] rd_data,
  output logic jump,
  output logic [core_pkg::xlen-1:0] jump_target,
  output logic exception,
  output core_pkg::ecause_t ecause
);

  import core_pkg::*;

  // Decoder outputs
  logic [xlen-1:0] instr;
  logic [xlen-1:0] imm;
  alu_op_t alu_op;
  bcu_op_t bcu_op;
  logic wren, rden1, rden2, use_imm, auipc, lui;
  logic jal, jalr, branch, ecall, ebreak, legal;

  logic [reg_addr_w-1:0] raddr1, raddr2;
  logic [xlen-1:0] rdata1, rdata2;

  logic ex_fwd_wren;
  logic [reg_addr_w-1:0] ex_fwd_addr;
  logic [xlen-1:0] ex_fwd_data;

  // Decode register
  logic d_valid, d_wren, d_use_imm, d_auipc, d_jal, d_jalr, d_branch, d_exception;
  logic [xlen-1:0] d_pc, d_imm, d_rs1_data, d_rs2_data;
  logic [reg_addr_w-1:0] d_waddr;
  alu_op_t d_alu_op;
  bcu_op_t d_bcu_op;
  ecause_t d_ecause;

  // Execute register
  logic e_valid, e_wren, e_jump, e_exception;
  logic [xlen-1:0] e_pc, e_wdata, e_target;
  logic [reg_addr_w-1:0] e_waddr;
  ecause_t e_ecause;

  instr_decoder i_instr_decoder (.*);

  reg_file #(
    .num_regs(num_regs)
  ) i_reg_file (
    .*,
    .wren(rd_wren), // Retire stage owns the write port
    .waddr(rd_addr),
    .wdata(rd_data)
  );

  decode_stage i_decode_stage (
    .*,
    .squash(e_jump),
    .mem_fwd_wren(e_wren),
    .mem_fwd_addr(e_waddr),
    .mem_fwd_data(e_wdata),
    .q_valid(d_valid),
    .q_pc(d_pc),
    .q_imm(d_imm),
    .q_rs1_data(d_rs1_data),
    .q_rs2_data(d_rs2_data),
    .q_waddr(d_waddr),
    .q_alu_op(d_alu_op),
    .q_bcu_op(d_bcu_op),
    .q_wren(d_wren),
    .q_use_imm(d_use_imm),
    .q_auipc(d_auipc),
    .q_jal(d_jal),
    .q_jalr(d_jalr),
    .q_branch(d_branch),
    .q_exception(d_exception),
    .q_ecause(d_ecause)
  );

  execute_stage i_execute_stage (
    .*,
    .q_valid(e_valid),
    .q_pc(e_pc),
    .q_wren(e_wren),
    .q_waddr(e_waddr),
    .q_wdata(e_wdata),
    .q_jump(e_jump),
    .q_target(e_target),
    .q_exception(e_exception),
    .q_ecause(e_ecause)
  );

  result_stage i_result_stage (.*);

endmodule

`default_nettype wire

// ==== logic/decode_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module decode_stage (
  input logic clk,
  input logic rst,
  input logic issue_valid,
  input logic [core_pkg::xlen-1:0] issue_instr,
  input logic [core_pkg::xlen-1:0] issue_pc,
  input logic squash,
  output logic [core_pkg::xlen-1:0] instr,
  input logic [core_pkg::xlen-1:0] imm,
  input core_pkg::alu_op_t alu_op,
  input core_pkg::bcu_op_t bcu_op,
  input logic wren,
  input logic rden1,
  input logic rden2,
  input logic use_imm,
  input logic auipc,
  input logic lui,
  input logic jal,
  input logic jalr,
  input logic branch,
  input logic ecall,
  input logic ebreak,
  input logic legal,
  output logic [core_pkg::reg_addr_w-1:0] raddr1,
  output logic [core_pkg::reg_addr_w-1:0] raddr2,
  input logic [core_pkg::xlen-1:0] rdata1,
  input logic [core_pkg::xlen-1:0] rdata2,
  input logic ex_fwd_wren,
  input logic [core_pkg::reg_addr_w-1:0] ex_fwd_addr,
  input logic [core_pkg::xlen-1:0] ex_fwd_data,
  input logic mem_fwd_wren,
  input logic [core_pkg::reg_addr_w-1:0] mem_fwd_addr,
  input logic [core_pkg::xlen-1:0] mem_fwd_data,
  output logic q_valid,
  output logic [core_pkg::xlen-1:0] q_pc,
  output logic [core_pkg::xlen-1:0] q_imm,
  output logic [core_pkg::xlen-1:0] q_rs1_data,
  output logic [core_pkg::xlen-1:0] q_rs2_data,
  output logic [core_pkg::reg_addr_w-1:0] q_waddr,
  output core_pkg::alu_op_t q_alu_op,
  output core_pkg::bcu_op_t q_bcu_op,
  output logic q_wren,
  output logic q_use_imm,
  output logic q_auipc,
  output logic q_jal,
  output logic q_jalr,
  output logic q_branch,
  output logic q_exception,
  output core_pkg::ecause_t q_ecause
);

  import core_pkg::*;

  logic capture;
  logic exception;
  ecause_t ecause;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;

  // The younger producer wins when both later stages write the same register
  function automatic logic [xlen-1:0] operand(input logic rden,
                                             input logic [reg_addr_w-1:0] addr,
                                             input logic [xlen-1:0] rdata);
    logic [xlen-1:0] value;
    if (!rden || addr == '0) begin
      value = '0;
    end else if (ex_fwd_wren && ex_fwd_addr == addr) begin
      value = ex_fwd_data;
    end else if (mem_fwd_wren && mem_fwd_addr == addr) begin
      value = mem_fwd_data;
    end else begin
      value = rdata;
    end
    return value;
  endfunction

  assign instr = issue_instr;
  assign raddr1 = issue_instr[19:15];
  assign raddr2 = issue_instr[24:20];

  always_comb begin
    rs1_data = operand(rden1, raddr1, rdata1);
    rs2_data = operand(rden2, raddr2, rdata2);
  end

  assign capture = issue_valid & ~squash; // Issue slot behind a taken jump is lost

  // Later checks override earlier ones, so ECALL has the highest priority
  always_comb begin
    exception = 1'b0;
    ecause = except_illegal_instruction;
    if (!legal) begin
      exception = 1'b1;
      ecause = except_illegal_instruction;
    end
    if (ebreak) begin
      exception = 1'b1;
      ecause = except_breakpoint;
    end
    if (ecall) begin
      exception = 1'b1;
      ecause = except_env_call_mach;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      q_valid <= 1'b0;
      q_wren <= 1'b0;
      q_auipc <= 1'b0;
      q_jal <= 1'b0;
      q_jalr <= 1'b0;
      q_branch <= 1'b0;
      q_exception <= 1'b0;
    end else begin
      q_valid <= capture;
      q_wren <= capture & wren;
      q_auipc <= capture & auipc;
      q_jal <= capture & jal;
      q_jalr <= capture & jalr;
      q_branch <= capture & branch;
      q_exception <= capture & exception;
    end
  end

  always_ff @(posedge clk) begin
    q_pc <= issue_pc;
    q_imm <= imm;
    q_rs1_data <= rs1_data;
    q_rs2_data <= rs2_data;
    q_waddr <= issue_instr[11:7];
    q_alu_op <= alu_op;
    q_bcu_op <= bcu_op;
    q_use_imm <= use_imm | lui; // LUI passes its immediate through the ALU
    q_ecause <= ecause;
  end

endmodule

`default_nettype wire

// ==== logic/execute_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module execute_stage (
  input logic clk,
  input logic rst,
  input logic d_valid,
  input logic [core_pkg::xlen-1:0] d_pc,
  input logic [core_pkg::xlen-1:0] d_imm,
  input logic [core_pkg::xlen-1:0] d_rs1_data,
  input logic [core_pkg::xlen-1:0] d_rs2_data,
  input logic [core_pkg::reg_addr_w-1:0] d_waddr,
  input core_pkg::alu_op_t d_alu_op,
  input core_pkg::bcu_op_t d_bcu_op,
  input logic d_wren,
  input logic d_use_imm,
  input logic d_auipc,
  input logic d_jal,
  input logic d_jalr,
  input logic d_branch,
  input logic d_exception,
  input core_pkg::ecause_t d_ecause,
  output logic ex_fwd_wren,
  output logic [core_pkg::reg_addr_w-1:0] ex_fwd_addr,
  output logic [core_pkg::xlen-1:0] ex_fwd_data,
  output logic q_valid,
  output logic [core_pkg::xlen-1:0] q_pc,
  output logic q_wren,
  output logic [core_pkg::reg_addr_w-1:0] q_waddr,
  output logic [core_pkg::xlen-1:0] q_wdata,
  output logic q_jump,
  output logic [core_pkg::xlen-1:0] q_target,
  output logic q_exception,
  output core_pkg::ecause_t q_ecause
);

  import core_pkg::*;

  logic live;
  logic taken;
  logic cond;
  logic [xlen-1:0] op_b;
  logic [4:0] shamt;
  logic [xlen-1:0] alu_out;
  logic [xlen-1:0] result;
  logic [xlen-1:0] target;

  // The instruction right behind a taken jump dies here
  assign live = d_valid & ~q_jump;

  assign op_b = d_use_imm ? d_imm : d_rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (d_alu_op)
      alu_add: alu_out = d_rs1_data + op_b;
      alu_sub: alu_out = d_rs1_data - op_b;
      alu_sll: alu_out = d_rs1_data << shamt;
      alu_slt: alu_out = {{(xlen-1){1'b0}}, $signed(d_rs1_data) < $signed(op_b)};
      alu_sltu: alu_out = {{(xlen-1){1'b0}}, d_rs1_data < op_b};
      alu_xor: alu_out = d_rs1_data ^ op_b;
      alu_srl: alu_out = d_rs1_data >> shamt;
      alu_sra: alu_out = $signed(d_rs1_data) >>> shamt;
      alu_or: alu_out = d_rs1_data | op_b;
      alu_and: alu_out = d_rs1_data & op_b;
      alu_pass_b: alu_out = op_b;
      default: alu_out = '0;
    endcase
  end

  always_comb begin
    case (d_bcu_op)
      bcu_beq: cond = (d_rs1_data == d_rs2_data);
      bcu_bne: cond = (d_rs1_data != d_rs2_data);
      bcu_blt: cond = ($signed(d_rs1_data) < $signed(d_rs2_data));
      bcu_bge: cond = ($signed(d_rs1_data) >= $signed(d_rs2_data));
      bcu_bltu: cond = (d_rs1_data < d_rs2_data);
      bcu_bgeu: cond = (d_rs1_data >= d_rs2_data);
      default: cond = 1'b0;
    endcase
  end

  always_comb begin
    if (d_jal || d_jalr) begin
      result = d_pc + 32'd4; // Link value
    end else if (d_auipc) begin
      result = d_pc + d_imm;
    end else begin
      result = alu_out;
    end

    if (d_jalr) begin
      target = d_rs1_data + d_imm;
      target[0] = 1'b0;
    end else begin
      target = d_pc + d_imm;
    end
  end

  assign taken = live & (d_jal | d_jalr | (d_branch & cond));

  assign ex_fwd_wren = live & d_wren;
  assign ex_fwd_addr = d_waddr;
  assign ex_fwd_data = result;

  always_ff @(posedge clk) begin
    if (!rst) begin
      q_valid <= 1'b0;
      q_wren <= 1'b0;
      q_jump <= 1'b0;
      q_exception <= 1'b0;
    end else begin
      q_valid <= live;
      q_wren <= live & d_wren;
      q_jump <= taken;
      q_exception <= live & d_exception;
    end
  end

  always_ff @(posedge clk) begin
    q_pc <= d_pc;
    q_waddr <= d_waddr;
    q_wdata <= result;
    q_target <= target;
    q_ecause <= d_ecause;
  end

endmodule

`default_nettype wire

// ==== logic/instr_decoder.sv ====
`default_nettype none
`timescale 1ns/1ps

module instr_decoder (
  input logic [core_pkg::xlen-1:0] instr,
  output logic [core_pkg::xlen-1:0] imm,
  output core_pkg::alu_op_t alu_op,
  output core_pkg::bcu_op_t bcu_op,
  output logic wren,
  output logic rden1,
  output logic rden2,
  output logic use_imm,
  output logic auipc,
  output logic lui,
  output logic jal,
  output logic jalr,
  output logic branch,
  output logic ecall,
  output logic ebreak,
  output logic legal
);

  import core_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_j;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    imm = imm_i;
    alu_op = alu_add;
    bcu_op = bcu_beq;
    wren = 1'b0;
    rden1 = 1'b0;
    rden2 = 1'b0;
    use_imm = 1'b0;
    auipc = 1'b0;
    lui = 1'b0;
    jal = 1'b0;
    jalr = 1'b0;
    branch = 1'b0;
    ecall = 1'b0;
    ebreak = 1'b0;
    legal = 1'b1;

    case (opcode)
      op_lui: begin
        imm = imm_u;
        alu_op = alu_pass_b;
        wren = 1'b1;
        lui = 1'b1;
      end
      op_auipc: begin
        imm = imm_u;
        wren = 1'b1;
        auipc = 1'b1;
      end
      op_jal: begin
        imm = imm_j;
        wren = 1'b1;
        jal = 1'b1;
      end
      op_jalr: begin
        wren = 1'b1;
        rden1 = 1'b1;
        jalr = 1'b1;
        legal = (funct3 == 3'b000);
      end
      op_branch: begin
        imm = imm_b;
        rden1 = 1'b1;
        rden2 = 1'b1;
        branch = 1'b1;
        case (funct3)
          3'b000: bcu_op = bcu_beq;
          3'b001: bcu_op = bcu_bne;
          3'b100: bcu_op = bcu_blt;
          3'b101: bcu_op = bcu_bge;
          3'b110: bcu_op = bcu_bltu;
          3'b111: bcu_op = bcu_bgeu;
          default: legal = 1'b0;
        endcase
      end
      op_imm: begin
        wren = 1'b1;
        rden1 = 1'b1;
        use_imm = 1'b1;
        case (funct3)
          3'b000: alu_op = alu_add;
          3'b010: alu_op = alu_slt;
          3'b011: alu_op = alu_sltu;
          3'b100: alu_op = alu_xor;
          3'b110: alu_op = alu_or;
          3'b111: alu_op = alu_and;
          3'b001: begin
            alu_op = alu_sll;
            legal = (funct7 == 7'b0000000);
          end
          default: begin
            alu_op = funct7[5] ? alu_sra : alu_srl;
            legal = ((funct7 & 7'b1011111) == 7'b0000000);
          end
        endcase
      end
      op_reg: begin
        wren = 1'b1;
        rden1 = 1'b1;
        rden2 = 1'b1;
        legal = ((funct7 & 7'b1011111) == 7'b0000000);
        case ({funct7[5], funct3})
          4'b0000: alu_op = alu_add;
          4'b1000: alu_op = alu_sub;
          4'b0001: alu_op = alu_sll;
          4'b0010: alu_op = alu_slt;
          4'b0011: alu_op = alu_sltu;
          4'b0100: alu_op = alu_xor;
          4'b0101: alu_op = alu_srl;
          4'b1101: alu_op = alu_sra;
          4'b0110: alu_op = alu_or;
          4'b0111: alu_op = alu_and;
          default: legal = 1'b0;
        endcase
      end
      op_system: begin
        ecall = (instr == instr_ecall);
        ebreak = (instr == instr_ebreak);
        legal = ecall | ebreak;
      end
      default: legal = 1'b0;
    endcase

    // An illegal word must not touch any state further down
    if (!legal) begin
      wren = 1'b0;
      rden1 = 1'b0;
      rden2 = 1'b0;
      use_imm = 1'b0;
      auipc = 1'b0;
      lui = 1'b0;
      jal = 1'b0;
      jalr = 1'b0;
      branch = 1'b0;
      ecall = 1'b0;
      ebreak = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`default_nettype none
`timescale 1ns/1ps

module reg_file #(
  parameter int num_regs = 32
) (
  input logic clk,
  input logic rst,
  input logic [core_pkg::reg_addr_w-1:0] raddr1,
  input logic [core_pkg::reg_addr_w-1:0] raddr2,
  input logic [core_pkg::reg_addr_w-1:0] waddr,
  input logic wren,
  input logic [core_pkg::xlen-1:0] wdata,
  output logic [core_pkg::xlen-1:0] rdata1,
  output logic [core_pkg::xlen-1:0] rdata2
);

  import core_pkg::*;

  logic [xlen-1:0] regs [num_regs];

  // Addresses beyond num_regs read as zero and drop writes (RV32E)
  function automatic logic [xlen-1:0] read_port(input logic [reg_addr_w-1:0] addr);
    logic [xlen-1:0] value;
    if (addr == '0 || int'(addr) >= num_regs) begin
      value = '0;
    end else if (wren && addr == waddr) begin
      value = wdata; // Write-through of the retiring result
    end else begin
      value = regs[addr];
    end
    return value;
  endfunction

  always_comb begin
    rdata1 = read_port(raddr1);
    rdata2 = read_port(raddr2);
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wren && waddr != '0 && int'(waddr) < num_regs) begin
      regs[waddr] <= wdata;
    end
  end

endmodule

`default_nettype wire

// ==== logic/result_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module result_stage (
  input logic clk,
  input logic rst,
  input logic e_valid,
  input logic [core_pkg::xlen-1:0] e_pc,
  input logic e_wren,
  input logic [core_pkg::reg_addr_w-1:0] e_waddr,
  input logic [core_pkg::xlen-1:0] e_wdata,
  input logic e_jump,
  input logic [core_pkg::xlen-1:0] e_target,
  input logic e_exception,
  input core_pkg::ecause_t e_ecause,
  output logic retire_valid,
  output logic [core_pkg::xlen-1:0] retire_pc,
  output logic rd_wren,
  output logic [core_pkg::reg_addr_w-1:0] rd_addr,
  output logic [core_pkg::xlen-1:0] rd_data,
  output logic jump,
  output logic [core_pkg::xlen-1:0] jump_target,
  output logic exception,
  output core_pkg::ecause_t ecause
);

  always_ff @(posedge clk) begin
    if (!rst) begin
      retire_valid <= 1'b0;
      rd_wren <= 1'b0;
      jump <= 1'b0;
      exception <= 1'b0;
    end else begin
      retire_valid <= e_valid;
      rd_wren <= e_valid & e_wren & ~e_exception & (e_waddr != '0);
      jump <= e_valid & e_jump;
      exception <= e_valid & e_exception;
    end
  end

  always_ff @(posedge clk) begin
    retire_pc <= e_pc;
    rd_addr <= e_waddr;
    rd_data <= e_wdata;
    jump_target <= e_target;
    ecause <= e_ecause;
  end

endmodule

`default_nettype wire

// ==== test/core_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_props (
  input logic clk,
  input logic rst,
  input logic retire_valid,
  input logic rd_wren,
  input logic [core_pkg::reg_addr_w-1:0] rd_addr,
  input logic jump,
  input logic exception
);

  // All retire flags are cleared one cycle into reset
  reset_clears_flags: assert property (@(posedge clk)
    !rst |=> !(retire_valid || rd_wren || jump || exception))
    else $error("Retire flags not cleared after reset");

  flags_need_valid: assert property (@(posedge clk) disable iff (!rst)
    (rd_wren || jump || exception) |-> retire_valid)
    else $error("Write, jump or exception reported without retire_valid");

  // The register file never sees a write from a faulting instruction or to x0
  write_is_clean: assert property (@(posedge clk) disable iff (!rst)
    rd_wren |-> (!exception && rd_addr != '0))
    else $error("Register write together with exception or to x0");

endmodule

`default_nettype wire

// ==== test/core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_tb;

  import core_pkg::*;

  localparam int num_instr = 2000;
  localparam int drain_limit = 10;

  typedef struct packed {
    int due;
    logic [31:0] pc;
    logic wren;
    logic [4:0] rd;
    logic [31:0] data;
    logic jump;
    logic [31:0] target;
    logic exc;
    logic [3:0] cause;
  } retire_t;

  logic clk;
  logic rst;
  logic issue_valid;
  logic [31:0] issue_instr;
  logic [31:0] issue_pc;
  logic retire_valid;
  logic [31:0] retire_pc;
  logic rd_wren;
  logic [4:0] rd_addr;
  logic [31:0] rd_data;
  logic jump;
  logic [31:0] jump_target;
  logic exception;
  ecause_t ecause;

  integer seed;
  int cycle;
  int issued;
  int squash_left;
  logic [31:0] pc;
  logic [31:0] redirect_pc;
  logic [31:0] regs [32]; // Architectural state of the reference model
  retire_t expected [$];

  core_top #(
    .num_regs(32)
  ) i_dut (.*);

  bind core_top core_props i_core_props (
    .clk(clk),
    .rst(rst),
    .retire_valid(retire_valid),
    .rd_wren(rd_wren),
    .rd_addr(rd_addr),
    .jump(jump),
    .exception(exception)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TB FAILED");
    $fatal(1, "Simulation stopped at cycle %0d", cycle);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp_value,
                             input logic [31:0] act_value);
    if (act_value !== exp_value) begin
      abort_run($sformatf("Error: %s expected %h actual %h", name, exp_value, act_value));
    end
  endtask

  function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
    logic [31:0] res;
    case (f3)
      3'd0: res = alt ? a - b : a + b;
      3'd1: res = a << b[4:0];
      3'd2: res = {31'b0, $signed(a) < $signed(b)};
      3'd3: res = {31'b0, a < b};
      3'd4: res = a ^ b;
      3'd5: begin
        if (alt) begin
          res = $signed(a) >>> b[4:0];
        end else begin
          res = a >> b[4:0];
        end
      end
      3'd6: res = a | b;
      default: res = a & b;
    endcase
    return res;
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic make_instr(output logic [31:0] word);
    logic [31:0] r;
    logic [2:0] f3;
    int kind;
    r = $random(seed) & ~32'h018c0c00; // Keeps rd, rs1 and rs2 within x0 to x7
    kind = {$random(seed)} % 16;
    f3 = r[14:12];
    case (kind)
      0, 1, 2, 3: word = {1'b0, r[30] & (f3 == 3'd0 || f3 == 3'd5), 5'b0, r[24:7], op_reg};
      4, 5, 6: begin
        word = {r[31:7], op_imm};
        if (f3 == 3'd1) begin
          word[31:25] = 7'b0;
        end else if (f3 == 3'd5) begin
          word[31:25] = {1'b0, r[30], 5'b0};
        end
      end
      7: word = {r[31:7], op_lui};
      8: word = {r[31:7], op_auipc};
      9: word = {r[31:7], op_jal};
      10: word = {r[31:15], 3'b000, r[11:7], op_jalr};
      11, 12: begin
        word = {r[31:7], op_branch};
        word[13] = word[13] & ~(f3 == 3'd2 || f3 == 3'd3);
      end
      13: word = r[0] ? instr_ecall : instr_ebreak;
      14: word = r;
      default: begin
        // Known opcode with random fields gives encodings close to legal ones
        case (r[1:0])
          2'd0: word = {r[31:7], op_reg};
          2'd1: word = {r[31:7], op_jalr};
          2'd2: word = {r[31:7], op_system};
          default: word = {r[31:7], op_imm};
        endcase
      end
    endcase
  endtask

  task automatic run_model(input logic [31:0] word, input logic [31:0] at_pc,
                           output retire_t exp);
    logic [2:0] f3;
    logic [6:0] f7;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic legal;
    f3 = word[14:12];
    f7 = word[31:25];
    a = regs[word[19:15]];
    b = regs[word[24:20]];
    imm_i = {{20{word[31]}}, word[31:20]};
    imm_b = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
    imm_j = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
    exp = '0;
    exp.due = cycle + 3;
    exp.pc = at_pc;
    exp.rd = word[11:7];
    legal = 1'b1;
    case (word[6:0])
      op_reg: begin
        legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        exp.data = alu_model(f3, f7[5], a, b);
        exp.wren = 1'b1;
      end
      op_imm: begin
        if (f3 == 3'd1) begin
          legal = (f7 == 7'h00);
        end else if (f3 == 3'd5) begin
          legal = (f7 == 7'h00) || (f7 == 7'h20);
        end
        exp.data = alu_model(f3, f3 == 3'd5 && f7[5], a, imm_i);
        exp.wren = 1'b1;
      end
      op_lui: begin
        exp.data = {word[31:12], 12'b0};
        exp.wren = 1'b1;
      end
      op_auipc: begin
        exp.data = at_pc + {word[31:12], 12'b0};
        exp.wren = 1'b1;
      end
      op_jal: begin
        exp.data = at_pc + 32'd4;
        exp.wren = 1'b1;
        exp.jump = 1'b1;
        exp.target = at_pc + imm_j;
      end
      op_jalr: begin
        legal = (f3 == 3'd0);
        exp.data = at_pc + 32'd4;
        exp.wren = 1'b1;
        exp.jump = 1'b1;
        exp.target = (a + imm_i) & ~32'd1;
      end
      op_branch: begin
        legal = (f3 != 3'd2) && (f3 != 3'd3);
        exp.jump = branch_taken(f3, a, b);
        exp.target = at_pc + imm_b;
      end
      op_system: begin
        legal = (word == instr_ecall) || (word == instr_ebreak);
        exp.exc = 1'b1;
        exp.cause = (word == instr_ecall) ? 4'd11 : 4'd3; // Machine ECALL and breakpoint
      end
      default: legal = 1'b0;
    endcase
    if (!legal) begin
      exp.wren = 1'b0;
      exp.jump = 1'b0;
      exp.exc = 1'b1;
      exp.cause = 4'd2;
    end
    if (exp.rd == 5'd0) begin
      exp.wren = 1'b0;
    end
    if (exp.wren) begin
      regs[exp.rd] = exp.data;
    end
  endtask

  task automatic check_retire();
    retire_t exp;
    if (retire_valid === 1'b1) begin
      if (expected.size() == 0) begin
        abort_run($sformatf("Instruction at pc %h retired but none was expected", retire_pc));
      end else begin
        exp = expected.pop_front();
        if (exp.due != cycle) begin
          abort_run($sformatf("Instruction at pc %h retired in cycle %0d instead of %0d",
                              exp.pc, cycle, exp.due));
        end
        check_value("retire_pc", exp.pc, retire_pc);
        check_value("rd_wren", exp.wren, rd_wren);
        check_value("jump", exp.jump, jump);
        check_value("exception", exp.exc, exception);
        if (exp.wren) begin
          check_value("rd_addr", exp.rd, rd_addr);
          check_value("rd_data", exp.data, rd_data);
        end
        if (exp.jump) begin
          check_value("jump_target", exp.target, jump_target);
        end
        if (exp.exc) begin
          check_value("ecause", exp.cause, ecause);
        end
      end
    end else if (expected.size() > 0 && expected[0].due <= cycle) begin
      abort_run($sformatf("Instruction at pc %h did not retire within 3 cycles",
                          expected[0].pc));
    end
  endtask

  task automatic drive_issue();
    retire_t exp;
    logic [31:0] word;
    make_instr(word);
    // Both slots behind a taken jump are always filled
    issue_valid = (squash_left > 0) || ({$random(seed)} % 4 != 0);
    issue_instr = word;
    issue_pc = pc;
    if (squash_left > 0) begin
      squash_left--;
      pc = (squash_left == 0) ? redirect_pc : pc + 32'd4;
    end else if (issue_valid) begin
      run_model(word, pc, exp);
      expected.push_back(exp);
      pc = pc + 32'd4;
      if (exp.jump) begin
        squash_left = 2;
        redirect_pc = exp.target;
      end
    end
    if (issue_valid) begin
      issued++;
    end
  endtask

  initial begin
    rst = 1'b0;
    issue_valid = 1'b0;
    issue_instr = '0;
    issue_pc = '0;
    seed = 32'h6f4c6445;
    cycle = 0;
    issued = 0;
    squash_left = 0;
    pc = 32'h0000_1000;
    redirect_pc = '0;
    for (int r = 0; r < 32; r++) begin
      regs[r] = '0;
    end
    repeat (16) @(negedge clk);
    rst = 1'b1;

    while (issued < num_instr) begin
      @(negedge clk);
      cycle++;
      check_retire();
      drive_issue();
    end

    for (int i = 0; i < drain_limit && expected.size() > 0; i++) begin
      @(negedge clk);
      cycle++;
      check_retire();
      issue_valid = 1'b0;
    end
    if (expected.size() > 0) begin
      abort_run("Pipeline still held instructions when the drain timed out");
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire
